// File: bench/clockGen.sv
`default_nettype none
`timescale 1ns/1ps

// free-running clock plus power-on reset
module clockGen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a rising edge, like any other input
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end
endmodule

`default_nettype wire

// File: bench/demodMonitorTb.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module demodMonitorTb;
    localparam int PERIOD_NS  = 40;
    localparam int DAC_CYCLES = 24;
    localparam int FLD_CYCLES = 80;
    localparam int MAG_CYCLES = 100;
    // reset, registers, dac sources, false lock, magnitude filter
    localparam int TOTAL_CYCLES = 10 + 40 + 9 * (DAC_CYCLES + 2) + (4 * FLD_CYCLES + 20)
                                + (4 * MAG_CYCLES + 10);
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * PERIOD_NS;
    localparam logic [3:0] SOURCES [9] = '{`DACSRC_I, `DACSRC_Q, `DACSRC_FREQ, `DACSRC_PHASE,
        `DACSRC_MAG, `DACSRC_AVGFREQ, `DACSRC_FREQERROR, 4'd7, 4'd15};

    logic                 clk;
    logic                 rstN;
    logic [`ADDR_W-1:0]   addr;
    logic [`DATA_W-1:0]   din;
    logic                 wr0, wr1, wr2, wr3, rd;
    logic [`DATA_W-1:0]   dout;
    logic [`SAMPLE_W-1:0] iDdc, qDdc;
    logic                 ddcSync;
    logic [`DET_W-1:0]    phase, freq, freqError;
    logic [`MAG_W-1:0]    mag;
    logic                 demodSync;
    logic                 highFreqOffset;
    demodPkg::demodMode   demodMode;
    logic [`SAMPLE_W-1:0] dac0Data, dac1Data, dac2Data;
    logic                 dac0Sync, dac1Sync, dac2Sync;

    string       testName;
    int          errorCount;
    int          errorsAtStart;
    int          testsRun;
    int          testsFailed;
    logic [31:0] lfsr;

    // reference model state
    logic [31:0]                 modeWord, dacSelWord, flWord, amtcWord;
    logic signed [`SAMPLE_W-1:0] sampleModel;
    logic signed [`SAMPLE_W-1:0] avgModel;
    logic                        highModel;
    logic [`ACCUM_W-1:0]         accumModel;
    logic [`DATA_W-1:0]          doutModel;
    logic [3:0]                  wrLanes;
    logic                        modelInSpace;
    logic [`SAMPLE_W:0]          dacModel [0:2];
    logic [`SAMPLE_W:0]          dacActual [0:2];

    clockGen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) clocks (.clk(clk), .rstN(rstN));

    demodMonitor UUT (.*);

    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic randomBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [`ADDR_W-1:0] regAddr(input logic [`OFFSET_W-1:0] offset);
        return {`SPACE_BITS, offset};
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] lanes);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // avg + alpha * (sample - avg) / 65536 wrapped to 18 bits
    function automatic logic [`SAMPLE_W-1:0] nextAverage(input logic signed [`SAMPLE_W-1:0] avg,
            input logic signed [`SAMPLE_W-1:0] sample, input logic [15:0] alpha);
        longint delta;
        longint scaled;
        delta  = longint'(sample) - longint'(avg);
        scaled = (delta * longint'(alpha)) >>> 16;
        return avg + scaled[`SAMPLE_W-1:0];
    endfunction

    function automatic longint absOf(input logic signed [`SAMPLE_W-1:0] v);
        longint w;
        w = longint'(v);
        return (w < 0) ? -w : w;
    endfunction

    function automatic logic [`ACCUM_W-1:0] nextAccum(input logic [`ACCUM_W-1:0] acc,
            input logic [`MAG_W-1:0] m, input logic [4:0] tc);
        logic [14:0] err;
        longint      errExt;
        err    = {2'b00, m} - acc[39:25];
        errExt = longint'($signed(err)) <<< tc;
        return acc + errExt[`ACCUM_W-1:0];
    endfunction

    // {sync, data} that a channel should show one cycle later
    function automatic logic [`SAMPLE_W:0] sourceValue(input logic [3:0] sel);
        logic [`DET_W-1:0] negFreq;
        negFreq = '0 - freq;
        case (sel)
            `DACSRC_Q:         return {ddcSync, qDdc};
            `DACSRC_FREQ:      return {demodSync, negFreq, 6'h0};
            `DACSRC_PHASE:     return {demodSync, phase, 6'h0};
            `DACSRC_MAG:       return {demodSync, ~accumModel[38], accumModel[37:21]};
            `DACSRC_AVGFREQ:   return {ddcSync, avgModel};
            `DACSRC_FREQERROR: return {demodSync, freqError, 6'h0};
            default:           return {ddcSync, iDdc};
        endcase
    endfunction

    assign wrLanes      = {wr3, wr2, wr1, wr0};
    assign modelInSpace = (addr[`ADDR_W-1:`OFFSET_W] == `SPACE_BITS);

    always_comb begin
        doutModel = '0;
        if (modelInSpace) begin
            case (addr[`OFFSET_W-1:0])
                `REG_MODE:      doutModel = modeWord;
                `REG_DACSEL:    doutModel = dacSelWord;
                `REG_FALSELOCK: doutModel = flWord;
                `REG_AMTC:      doutModel = amtcWord;
                `REG_STATUS:    doutModel = {31'h0, highModel};
                default:        doutModel = '0;
            endcase
        end
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modeWord    <= '0;
            dacSelWord  <= '0;
            flWord      <= {16'hffff, 16'h0};
            amtcWord    <= '0;
            sampleModel <= '0;
            avgModel    <= '0;
            highModel   <= 1'b0;
            accumModel  <= '0;
            for (int ch = 0; ch < 3; ch++) begin
                dacModel[ch] <= '0;
            end
        end else begin
            if (modelInSpace && wrLanes != 4'h0) begin
                case (addr[`OFFSET_W-1:0])
                    `REG_MODE:      modeWord <= mergeLanes(modeWord, din, wrLanes) & 32'hf;
                    `REG_DACSEL:    dacSelWord <= mergeLanes(dacSelWord, din, wrLanes) & 32'hfff;
                    `REG_FALSELOCK: flWord <= mergeLanes(flWord, din, wrLanes);
                    `REG_AMTC:      amtcWord <= mergeLanes(amtcWord, din, wrLanes) & 32'h1f;
                    default:        ;
                endcase
            end
            if (demodSync) begin
                // offset QPSK modes average freq and the others freqError
                if (modeWord[3:0] == demodPkg::MODE_OQPSK
                        || modeWord[3:0] == demodPkg::MODE_SOQPSK) begin
                    sampleModel <= {freq, 6'h0};
                end else begin
                    sampleModel <= {freqError, 6'h0};
                end
                avgModel   <= nextAverage(avgModel, sampleModel, flWord[15:0]);
                highModel  <= absOf(avgModel) > longint'(flWord[31:16]);
                accumModel <= nextAccum(accumModel, mag, amtcWord[4:0]);
            end
            for (int ch = 0; ch < 3; ch++) begin
                dacModel[ch] <= sourceValue(dacSelWord[4*ch +: 4]);
            end
        end
    end

    resetState: assert property (@(posedge clk) $rose(rstN) |->
        (!dac0Sync && !dac1Sync && !dac2Sync && !highFreqOffset
         && demodMode == demodPkg::MODE_FM && dout == 32'h0))
        else begin
            errorCount++;
            $display("** Error [%s] reset {syncs, flag, mode, dout}: expected %h, actual %h",
                     testName, 40'h0, $sampled({dac0Sync, dac1Sync, dac2Sync, highFreqOffset,
                                                demodMode, dout}));
        end

    readbackMatches: assert property (@(posedge clk) disable iff (!rstN) dout == doutModel)
        else begin
            errorCount++;
            $display("** Error [%s] dout at %h: expected %h, actual %h", testName,
                     $sampled(addr), $sampled(doutModel), $sampled(dout));
        end

    modeMatches: assert property (@(posedge clk) disable iff (!rstN) demodMode == modeWord[3:0])
        else begin
            errorCount++;
            $display("** Error [%s] demodMode: expected %h, actual %h", testName,
                     $sampled(modeWord[3:0]), $sampled(demodMode));
        end

    flagMatches: assert property (@(posedge clk) disable iff (!rstN) highFreqOffset == highModel)
        else begin
            errorCount++;
            $display("** Error [%s] highFreqOffset: expected %b, actual %b", testName,
                     $sampled(highModel), $sampled(highFreqOffset));
        end

    assign dacActual[0] = {dac0Sync, dac0Data};
    assign dacActual[1] = {dac1Sync, dac1Data};
    assign dacActual[2] = {dac2Sync, dac2Data};

    for (genvar ch = 0; ch < 3; ch++) begin : dacChecks
        dacMatches: assert property (@(posedge clk) disable iff (!rstN)
            dacActual[ch] == dacModel[ch])
            else begin
                errorCount++;
                $display("** Error [%s] dac%0d {sync,data}: expected %h, actual %h", testName,
                         ch, $sampled(dacModel[ch]), $sampled(dacActual[ch]));
            end
    end

    task automatic busWrite(input logic [`ADDR_W-1:0] a, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(posedge clk);
        addr <= a;
        din  <= data;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'h0;
    endtask

    // a read only moves the address for the readback check
    task automatic busRead(input logic [`ADDR_W-1:0] a);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        rd   <= 1'b0;
    endtask

    task automatic driveCycle(input logic [`DET_W-1:0] freqBias, input int freqBits,
                              input logic [`MAG_W-1:0] magBase, input int magBits);
        logic [31:0] r;
        @(posedge clk);
        randomBits(18, r);
        iDdc <= r[17:0];
        randomBits(18, r);
        qDdc <= r[17:0];
        randomBits(12, r);
        phase <= r[11:0];
        randomBits(freqBits, r);
        freq <= freqBias + r[11:0];
        randomBits(freqBits, r);
        freqError <= freqBias + r[11:0];
        randomBits(magBits, r);
        mag <= magBase + r[12:0];
        randomBits(1, r);
        ddcSync <= r[0];
        randomBits(1, r);
        demodSync <= r[0];
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        // magnitude path reaches the dac three edges after the last drive
        repeat (3) @(posedge clk);
        @(negedge clk);
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("%s: passed", testName);
        end else begin
            testsFailed++;
            $display("%s: failed, %0d errors", testName, errorCount - errorsAtStart);
        end
    endtask

    initial begin
        addr      = regAddr(`REG_STATUS);
        din       = '0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        rd        = 1'b0;
        iDdc      = '0;
        qDdc      = '0;
        ddcSync   = 1'b0;
        phase     = '0;
        freq      = '0;
        freqError = '0;
        mag       = '0;
        demodSync = 1'b0;
        lfsr          = 32'haa236e4b;
        errorCount    = 0;
        testsRun      = 0;
        testsFailed   = 0;
        startTest("resetState");
        @(posedge rstN);
        repeat (3) @(posedge clk);
        finishTest();

        startTest("registerAccess");
        busWrite(regAddr(`REG_DACSEL), 32'hffff_fa51, 4'hf);
        busWrite(regAddr(`REG_FALSELOCK), 32'h1234_5678, 4'b0001);
        busWrite(regAddr(`REG_FALSELOCK), 32'h9abc_def0, 4'b0100);
        busWrite(regAddr(`REG_FALSELOCK), 32'h0000_4000, 4'b0010);
        busWrite(regAddr(`REG_MODE), 32'h0000_0002, 4'b0001);
        busWrite(regAddr(`REG_MODE), 32'hffff_ff03, 4'b1110);
        busWrite(regAddr(`REG_AMTC), 32'h0000_0013, 4'hf);
        busWrite(regAddr(5'h14), 32'hffff_ffff, 4'hf);
        // MODE offset outside the monitor space
        busWrite(12'h020, 32'h0000_0004, 4'hf);
        busRead(regAddr(`REG_MODE));
        busRead(regAddr(`REG_DACSEL));
        busRead(regAddr(`REG_FALSELOCK));
        busRead(regAddr(`REG_AMTC));
        busRead(regAddr(`REG_STATUS));
        busRead(regAddr(5'h1c));
        busRead(12'h000);
        busRead(12'hfff);
        finishTest();

        startTest("dacSourceSelect");
        for (int i = 0; i < 9; i++) begin
            busWrite(regAddr(`REG_DACSEL),
                     {20'h0, SOURCES[(i + 2) % 9], SOURCES[(i + 1) % 9], SOURCES[i]}, 4'h3);
            repeat (DAC_CYCLES) driveCycle(12'h000, 12, 13'h0, 13);
        end
        finishTest();

        startTest("falseLock");
        busWrite(regAddr(`REG_DACSEL),
                 {20'h0, `DACSRC_MAG, `DACSRC_FREQERROR, `DACSRC_AVGFREQ}, 4'h3);
        busWrite(regAddr(`REG_FALSELOCK), {16'h8000, 16'h2000}, 4'hf);
        busWrite(regAddr(`REG_MODE), {28'h0, demodPkg::MODE_FM}, 4'h1);
        busRead(regAddr(`REG_STATUS));
        // biased error pushes the average over the threshold and then lets it decay
        repeat (FLD_CYCLES) driveCycle(12'h300, 6, 13'h0, 13);
        repeat (FLD_CYCLES) driveCycle(12'h000, 6, 13'h0, 13);
        busWrite(regAddr(`REG_MODE), {28'h0, demodPkg::MODE_OQPSK}, 4'h1);
        busRead(regAddr(`REG_STATUS));
        repeat (FLD_CYCLES) driveCycle(12'hd00, 6, 13'h0, 13);
        repeat (FLD_CYCLES) driveCycle(12'h000, 6, 13'h0, 13);
        finishTest();

        startTest("magnitudeFilter");
        busWrite(regAddr(`REG_DACSEL), {20'h0, `DACSRC_MAG, `DACSRC_MAG, `DACSRC_MAG}, 4'h3);
        busWrite(regAddr(`REG_AMTC), 32'd20, 4'h1);
        repeat (MAG_CYCLES) driveCycle(12'h000, 12, 13'h0a00, 0);
        repeat (MAG_CYCLES) driveCycle(12'h000, 12, 13'h0, 13);
        busWrite(regAddr(`REG_AMTC), 32'd24, 4'h1);
        repeat (MAG_CYCLES) driveCycle(12'h000, 12, 13'h0a00, 0);
        repeat (MAG_CYCLES) driveCycle(12'h000, 12, 13'h0, 13);
        finishTest();

        $display("tests run %0d, failed %0d, assertion errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/demodPkg.sv
hdl/detectorIf.sv
hdl/monitorRegs.sv
hdl/falseLockDetector.sv
hdl/magnitudeFilter.sv
hdl/dacOutputMux.sv
hdl/demodMonitor.sv
bench/clockGen.sv
bench/demodMonitorTb.sv

// File: hdl/dacOutputMux.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module dacOutputMux (
    input  logic                 clk,
    input  logic                 rstN,
    input  demodPkg::dacSource   select,
    detectorIf.snk               det,
    input  logic [`SAMPLE_W-1:0] iDdc,
    input  logic [`SAMPLE_W-1:0] qDdc,
    input  logic                 ddcSync,
    input  logic [`SAMPLE_W-1:0] magLevel,
    input  logic [`SAMPLE_W-1:0] averageFreq,
    output logic [`SAMPLE_W-1:0] dacData,
    output logic                 dacSync
);
    logic [`DET_W-1:0] negFreq;

    // freq is shown inverted on the scope
    assign negFreq = -det.freq;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacData <= '0;
            dacSync <= 1'b0;
        end else begin
            case (select)
                demodPkg::DAC_Q: begin
                    dacData <= qDdc;
                    dacSync <= ddcSync;
                end
                demodPkg::DAC_FREQ: begin
                    dacData <= {negFreq, 6'h0};
                    dacSync <= det.demodSync;
                end
                demodPkg::DAC_PHASE: begin
                    dacData <= {det.phase, 6'h0};
                    dacSync <= det.demodSync;
                end
                demodPkg::DAC_MAG: begin
                    dacData <= magLevel;
                    dacSync <= det.demodSync;
                end
                demodPkg::DAC_AVGFREQ: begin
                    dacData <= averageFreq;
                    dacSync <= ddcSync;
                end
                demodPkg::DAC_FREQERROR: begin
                    dacData <= {det.freqError, 6'h0};
                    dacSync <= det.demodSync;
                end
                // I and any unlisted code
                default: begin
                    dacData <= iDdc;
                    dacSync <= ddcSync;
                end
            endcase
        end
    end

    syncKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(dacSync));

endmodule

`default_nettype wire

// File: hdl/demodMonitor.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module demodMonitor (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [`ADDR_W-1:0]   addr,
    input  logic [`DATA_W-1:0]   din,
    input  logic                 wr0,
    input  logic                 wr1,
    input  logic                 wr2,
    input  logic                 wr3,
    input  logic                 rd,
    output logic [`DATA_W-1:0]   dout,
    input  logic [`SAMPLE_W-1:0] iDdc,
    input  logic [`SAMPLE_W-1:0] qDdc,
    input  logic                 ddcSync,
    input  logic [`DET_W-1:0]    phase,
    input  logic [`DET_W-1:0]    freq,
    input  logic [`DET_W-1:0]    freqError,
    input  logic [`MAG_W-1:0]    mag,
    input  logic                 demodSync,
    output logic                 highFreqOffset,
    output demodPkg::demodMode   demodMode,
    output logic [`SAMPLE_W-1:0] dac0Data,
    output logic [`SAMPLE_W-1:0] dac1Data,
    output logic [`SAMPLE_W-1:0] dac2Data,
    output logic                 dac0Sync,
    output logic                 dac1Sync,
    output logic                 dac2Sync
);
    demodPkg::dacSource   dac0Select;
    demodPkg::dacSource   dac1Select;
    demodPkg::dacSource   dac2Select;
    logic [15:0]          falseLockAlpha;
    logic [15:0]          falseLockThreshold;
    logic [4:0]           amTC;
    logic [`SAMPLE_W-1:0] averageFreq;
    logic [`SAMPLE_W-1:0] magLevel;

    // detector results enter as plain ports
    detectorIf det ();
    assign det.phase     = phase;
    assign det.freq      = freq;
    assign det.freqError = freqError;
    assign det.mag       = mag;
    assign det.demodSync = demodSync;

    // rd has no side effects, readback is combinational
    monitorRegs regs (
        .clk(clk), .rstN(rstN), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .dout(dout),
        .highFreqOffset(highFreqOffset), .demodMode(demodMode),
        .dac0Select(dac0Select), .dac1Select(dac1Select), .dac2Select(dac2Select),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold),
        .amTC(amTC)
    );

    falseLockDetector fld (
        .clk(clk), .rstN(rstN), .det(det.snk), .demodMode(demodMode),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold),
        .averageFreq(averageFreq), .highFreqOffset(highFreqOffset)
    );

    magnitudeFilter magFilter (
        .clk(clk), .rstN(rstN), .det(det.snk), .amTC(amTC), .magLevel(magLevel)
    );

    dacOutputMux dac0 (
        .clk(clk), .rstN(rstN), .select(dac0Select), .det(det.snk),
        .iDdc(iDdc), .qDdc(qDdc), .ddcSync(ddcSync), .magLevel(magLevel),
        .averageFreq(averageFreq), .dacData(dac0Data), .dacSync(dac0Sync)
    );

    dacOutputMux dac1 (
        .clk(clk), .rstN(rstN), .select(dac1Select), .det(det.snk),
        .iDdc(iDdc), .qDdc(qDdc), .ddcSync(ddcSync), .magLevel(magLevel),
        .averageFreq(averageFreq), .dacData(dac1Data), .dacSync(dac1Sync)
    );

    dacOutputMux dac2 (
        .clk(clk), .rstN(rstN), .select(dac2Select), .det(det.snk),
        .iDdc(iDdc), .qDdc(qDdc), .ddcSync(ddcSync), .magLevel(magLevel),
        .averageFreq(averageFreq), .dacData(dac2Data), .dacSync(dac2Sync)
    );

endmodule

`default_nettype wire

// File: hdl/demodMonitor_cfg.svh
`ifndef DEMOD_MONITOR_CFG_SVH
`define DEMOD_MONITOR_CFG_SVH

// datapath widths
`define SAMPLE_W 18
`define DET_W 12
`define MAG_W 13
`define ACCUM_W 40

// microprocessor bus
`define ADDR_W 12
`define DATA_W 32
`define OFFSET_W 5
`define SPACE_BITS 7'h10

// register offsets inside the monitor space
`define REG_MODE 5'h00
`define REG_DACSEL 5'h04
`define REG_FALSELOCK 5'h08
`define REG_AMTC 5'h0c
`define REG_STATUS 5'h10

`define THRESHOLD_RESET 16'hffff

// dac source codes
`define DACSRC_I 4'd0
`define DACSRC_Q 4'd1
`define DACSRC_FREQ 4'd4
`define DACSRC_PHASE 4'd5
`define DACSRC_MAG 4'd6
`define DACSRC_AVGFREQ 4'd10
`define DACSRC_FREQERROR 4'd11

`endif

// File: hdl/demodPkg.sv
`default_nettype none
`include "demodMonitor_cfg.svh"

package demodPkg;

    // demodulator operating mode, reset value is FM
    typedef enum logic [3:0] {
        MODE_FM     = 4'd0,
        MODE_PM     = 4'd1,
        MODE_2FSK   = 4'd2,
        MODE_OQPSK  = 4'd3,
        MODE_SOQPSK = 4'd4
    } demodMode;

    // signals that can be routed to a dac channel
    typedef enum logic [3:0] {
        DAC_I         = `DACSRC_I,
        DAC_Q         = `DACSRC_Q,
        DAC_FREQ      = `DACSRC_FREQ,
        DAC_PHASE     = `DACSRC_PHASE,
        DAC_MAG       = `DACSRC_MAG,
        DAC_AVGFREQ   = `DACSRC_AVGFREQ,
        DAC_FREQERROR = `DACSRC_FREQERROR
    } dacSource;

endpackage

`default_nettype wire

// File: hdl/detectorIf.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

// phase/freq/mag detector results, valid while demodSync is high
interface detectorIf;
    logic [`DET_W-1:0] phase;
    logic [`DET_W-1:0] freq;
    logic [`DET_W-1:0] freqError;
    logic [`MAG_W-1:0] mag;
    logic              demodSync;

    modport src(output phase, freq, freqError, mag, demodSync);
    modport snk(input phase, freq, freqError, mag, demodSync);
endinterface

`default_nettype wire

// File: hdl/falseLockDetector.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module falseLockDetector (
    input  logic                        clk,
    input  logic                        rstN,
    detectorIf.snk                      det,
    input  demodPkg::demodMode          demodMode,
    input  logic [15:0]                 falseLockAlpha,
    input  logic [15:0]                 falseLockThreshold,
    output logic signed [`SAMPLE_W-1:0] averageFreq,
    output logic                        highFreqOffset
);
    logic                        offsetModes;
    logic signed [`SAMPLE_W-1:0] freqSample;
    logic signed [`SAMPLE_W:0]   diff;
    logic signed [`SAMPLE_W+17:0] product;
    logic signed [`SAMPLE_W+17:0] step;
    logic [`SAMPLE_W-1:0]        absAverage;

    // offset QPSK modes have no freqError, so the raw freq is averaged
    assign offsetModes = (demodMode == demodPkg::MODE_OQPSK)
                      || (demodMode == demodPkg::MODE_SOQPSK);

    // avg += alpha * (sample - avg) / 2^16
    assign diff    = {freqSample[`SAMPLE_W-1], freqSample}
                   - {averageFreq[`SAMPLE_W-1], averageFreq};
    assign product = diff * $signed({1'b0, falseLockAlpha});
    assign step    = product >>> 16;

    assign absAverage = averageFreq[`SAMPLE_W-1] ? -averageFreq : averageFreq;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            freqSample     <= '0;
            averageFreq    <= '0;
            highFreqOffset <= 1'b0;
        end else if (det.demodSync) begin
            freqSample     <= offsetModes ? {det.freq, 6'h0} : {det.freqError, 6'h0};
            averageFreq    <= averageFreq + step[`SAMPLE_W-1:0];
            highFreqOffset <= (absAverage > {2'b00, falseLockThreshold});
        end
    end

    // flag only moves on a detector strobe
    flagOnStrobe: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(highFreqOffset) |-> $past(det.demodSync));

endmodule

`default_nettype wire

// File: hdl/magnitudeFilter.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module magnitudeFilter (
    input  logic                 clk,
    input  logic                 rstN,
    detectorIf.snk               det,
    input  logic [4:0]           amTC,
    output logic [`SAMPLE_W-1:0] magLevel
);
    logic [`ACCUM_W-1:0] accum;
    logic [14:0]         magError;
    logic [`ACCUM_W-1:0] errorExt;

    // error against the top of the accumulator
    assign magError = {2'b00, det.mag} - accum[39:25];
    assign errorExt = {{(`ACCUM_W-15){magError[14]}}, magError} << amTC;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            accum <= '0;
        end else if (det.demodSync) begin
            accum <= accum + errorExt;
        end
    end

    // offset binary to two's complement for the dac
    assign magLevel = {~accum[38], accum[37:21]};

    accumHolds: assert property (@(posedge clk) disable iff (!rstN)
        !det.demodSync |=> $stable(accum));

endmodule

`default_nettype wire

// File: hdl/monitorRegs.sv
`default_nettype none
`timescale 1ns/1ps
`include "demodMonitor_cfg.svh"

module monitorRegs (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`ADDR_W-1:0]         addr,
    input  logic [`DATA_W-1:0]         din,
    input  logic                       wr0,
    input  logic                       wr1,
    input  logic                       wr2,
    input  logic                       wr3,
    output logic [`DATA_W-1:0]         dout,
    input  logic                       highFreqOffset,
    output demodPkg::demodMode         demodMode,
    output demodPkg::dacSource         dac0Select,
    output demodPkg::dacSource         dac1Select,
    output demodPkg::dacSource         dac2Select,
    output logic [15:0]                falseLockAlpha,
    output logic [15:0]                falseLockThreshold,
    output logic [4:0]                 amTC
);
    logic                 inSpace;
    logic [`OFFSET_W-1:0] offset;
    logic [`DATA_W-1:0]   readWord;
    logic [`DATA_W-1:0]   laneMask;
    logic [`DATA_W-1:0]   merged;
    logic [3:0]           modeReg;
    logic [11:0]          dacSelReg;
    logic [31:0]          falseLockReg;
    logic [4:0]           amTCReg;

    assign inSpace = (addr[`ADDR_W-1:`OFFSET_W] == `SPACE_BITS);
    assign offset  = addr[`OFFSET_W-1:0];

    // readback of the addressed word, unmapped offsets read 0
    always_comb begin
        case (offset)
            `REG_MODE:      readWord = {28'h0, modeReg};
            `REG_DACSEL:    readWord = {20'h0, dacSelReg};
            `REG_FALSELOCK: readWord = falseLockReg;
            `REG_AMTC:      readWord = {27'h0, amTCReg};
            `REG_STATUS:    readWord = {31'h0, highFreqOffset};
            default:        readWord = '0;
        endcase
    end

    assign dout = inSpace ? readWord : '0;

    // byte lanes not being written keep the old contents
    assign laneMask = {{8{wr3}}, {8{wr2}}, {8{wr1}}, {8{wr0}}};
    assign merged   = (readWord & ~laneMask) | (din & laneMask);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modeReg      <= '0;
            dacSelReg    <= '0;
            falseLockReg <= {`THRESHOLD_RESET, 16'h0};
            amTCReg      <= '0;
        end else if (inSpace && (wr0 || wr1 || wr2 || wr3)) begin
            case (offset)
                `REG_MODE:      modeReg      <= merged[3:0];
                `REG_DACSEL:    dacSelReg    <= merged[11:0];
                `REG_FALSELOCK: falseLockReg <= merged;
                `REG_AMTC:      amTCReg      <= merged[4:0];
                default:        ;
            endcase
        end
    end

    assign demodMode          = demodPkg::demodMode'(modeReg);
    assign dac0Select         = demodPkg::dacSource'(dacSelReg[3:0]);
    assign dac1Select         = demodPkg::dacSource'(dacSelReg[7:4]);
    assign dac2Select         = demodPkg::dacSource'(dacSelReg[11:8]);
    assign falseLockAlpha     = falseLockReg[15:0];
    assign falseLockThreshold = falseLockReg[31:16];
    assign amTC               = amTCReg;

    // selects drive the dac muxes every cycle
    selectKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(dacSelReg));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile and run the demodMonitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module demodMonitorTb -Mdir obj_dir -o simDemodMonitor

output="$(./obj_dir/simDemodMonitor)"
echo "$output"

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi
